// File: design/acc_pkg.sv
// Accelerator dispatch package: sizes, vector types, class enums and interface structs
package acc_pkg;

  // Scoreboard and transaction ID sizing
  localparam int unsigned NR_SB_ENTRIES = 8;
  localparam int unsigned TRANS_ID_BITS = 3;
  // Datapath width
  localparam int unsigned XLEN          = 32;
  // Instruction queue depth and load/store counter width
  localparam int unsigned QUEUE_DEPTH   = 3;
  localparam int unsigned CNT_BITS      = 3;

  typedef logic [TRANS_ID_BITS-1:0] trans_id_t;
  typedef logic [XLEN-1:0]          xlen_t;
  // Raw accelerator instruction word
  typedef logic [31:0]              insn_t;
  // Floating-point rounding mode
  typedef logic [2:0]               frm_t;

  // Functional unit class of a scoreboard entry
  typedef enum logic [1:0] {NONE, LOAD, STORE, ACCEL} fu_e;

  // Memory behaviour of an accelerator instruction
  typedef enum logic [1:0] {OTHER, ACC_LOAD, ACC_STORE} acc_op_e;

  // Instruction offered by the issue stage
  typedef struct packed {
    logic      valid;
    fu_e       fu;
    acc_op_e   op;
    trans_id_t trans_id;
  } issue_entry_t;

  // Operands that follow an issued instruction by one cycle
  typedef struct packed {
    insn_t     insn;
    xlen_t     operand_a;
    xlen_t     operand_b;
    trans_id_t trans_id;
    acc_op_e   op;
  } fu_data_t;

  // Scoreboard head seen by the commit stage
  typedef struct packed {
    logic      valid;
    fu_e       fu;
    trans_id_t trans_id;
  } commit_entry_t;

  // Request channel towards the accelerator
  typedef struct packed {
    logic      req_valid;
    insn_t     insn;
    xlen_t     rs1;
    xlen_t     rs2;
    frm_t      frm;
    trans_id_t trans_id;
    logic      store_pending;
    logic      cons_en;
    logic      resp_ready;
  } acc_req_t;

  // Response channel from the accelerator
  typedef struct packed {
    logic      req_ready;
    logic      resp_valid;
    trans_id_t trans_id;
    xlen_t     result;
    logic      error;
    logic      load_complete;
    logic      store_complete;
    logic      store_pending;
  } acc_resp_t;

endpackage

// File: design/acc_insn_queue.sv
// Fall-through circular instruction queue with occupancy count and flush
`timescale 1ns/1ps

module acc_insn_queue import acc_pkg::*; (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  logic                                 flush_i,
  input  logic                                 push_i,
  input  fu_data_t                             data_i,
  input  logic                                 pop_i,
  output fu_data_t                             data_o,
  output logic                                 empty_o,
  output logic [$clog2(QUEUE_DEPTH+1)-1:0]     usage_o
);

  logic [$clog2(QUEUE_DEPTH)-1:0]   wr_ptr_q, rd_ptr_q;
  logic [$clog2(QUEUE_DEPTH+1)-1:0] usage_q;
  fu_data_t                         mem_q [QUEUE_DEPTH];
  logic                             full;
  logic                             push_eff, pop_eff, bypass;

  assign full     = (usage_q == QUEUE_DEPTH);
  // Pushes into a full queue are dropped, issue stall keeps this from happening
  assign push_eff = push_i & ~full;
  // Empty output already accounts for the fall-through push
  assign pop_eff  = pop_i & ~empty_o;
  // Entry goes straight through and never touches storage
  assign bypass   = push_eff & pop_eff & (usage_q == '0);

  always_comb begin
    data_o  = mem_q[rd_ptr_q];
    empty_o = (usage_q == '0) & ~push_i;
    // Empty buffer shows the incoming entry in the same cycle
    if (usage_q == '0) begin
      data_o = data_i;
    end
  end

  assign usage_o = usage_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (push_eff && !bypass) begin
        wr_ptr_q <= (wr_ptr_q == QUEUE_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_eff && !bypass) begin
        rd_ptr_q <= (rd_ptr_q == QUEUE_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the count unchanged
      if (push_eff && !pop_eff) begin
        usage_q <= usage_q + 1'b1;
      end else if (pop_eff && !push_eff) begin
        usage_q <= usage_q - 1'b1;
      end
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (push_eff && !bypass && !flush_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// File: design/acc_spec_tracker.sv
// Pending and non-speculative bitmaps per transaction ID with commit bypass
`timescale 1ns/1ps

module acc_spec_tracker import acc_pkg::*; (
  input  logic          clk_i,
  input  logic          arst_n_i,
  input  logic          flush_i,
  input  logic          push_i,
  input  trans_id_t     push_id_i,
  input  commit_entry_t commit_i,
  input  trans_id_t     head_id_i,
  input  logic          disp_i,
  input  trans_id_t     disp_id_i,
  output logic          head_ready_o
);

  // Received by the dispatcher, still speculative
  logic [NR_SB_ENTRIES-1:0] pending_d, pending_q;
  // Reached the scoreboard head, may go to the accelerator
  logic [NR_SB_ENTRIES-1:0] ready_d, ready_q;
  logic                     commit_hit;

  // Unfinished accelerator entry at the head that we actually hold
  assign commit_hit = ~commit_i.valid & (commit_i.fu == ACCEL) &
                      pending_q[commit_i.trans_id];

  always_comb begin
    pending_d = pending_q;
    ready_d   = ready_q;
    // New instruction entered the queue
    if (push_i) begin
      pending_d[push_id_i] = 1'b1;
    end
    // Speculative entries vanish on flush
    if (flush_i) begin
      pending_d = '0;
    end
    // Head of scoreboard, no longer speculative
    if (commit_hit) begin
      ready_d[commit_i.trans_id]   = 1'b1;
      pending_d[commit_i.trans_id] = 1'b0;
    end
    // Sent to the accelerator
    if (disp_i) begin
      ready_d[disp_id_i] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= '0;
      ready_q   <= '0;
    end else begin
      pending_q <= pending_d;
      ready_q   <= ready_d;
    end
  end

  // Either already ready, or committed right now
  assign head_ready_o = ready_q[head_id_i] |
                        (commit_hit & (commit_i.trans_id == head_id_i));

endmodule

// File: design/acc_mem_tracker.sv
// Speculative and dispatched accelerator load/store counters with no-pending flags
`timescale 1ns/1ps

module acc_mem_tracker import acc_pkg::*; (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic flush_i,
  input  logic spec_ld_i,
  input  logic spec_st_i,
  input  logic disp_ld_i,
  input  logic disp_st_i,
  input  logic ld_done_i,
  input  logic st_done_i,
  output logic no_ld_pending_o,
  output logic no_st_pending_o
);

  // Counter slots
  localparam int unsigned SPEC_LD = 0;
  localparam int unsigned SPEC_ST = 1;
  localparam int unsigned DISP_LD = 2;
  localparam int unsigned DISP_ST = 3;

  logic [3:0][CNT_BITS-1:0] cnt_q;
  logic [3:0]               cnt_up, cnt_dn, cnt_clr;

  // Speculative counters move into the dispatched ones at dispatch
  assign cnt_up[SPEC_LD]  = spec_ld_i;
  assign cnt_dn[SPEC_LD]  = disp_ld_i;
  assign cnt_up[SPEC_ST]  = spec_st_i;
  assign cnt_dn[SPEC_ST]  = disp_st_i;
  // Dispatched ones drain on completion from the accelerator
  assign cnt_up[DISP_LD]  = disp_ld_i;
  assign cnt_dn[DISP_LD]  = ld_done_i;
  assign cnt_up[DISP_ST]  = disp_st_i;
  assign cnt_dn[DISP_ST]  = st_done_i;

  // Only speculative accesses can be flushed
  assign cnt_clr[SPEC_LD] = flush_i;
  assign cnt_clr[SPEC_ST] = flush_i;
  assign cnt_clr[DISP_LD] = 1'b0;
  assign cnt_clr[DISP_ST] = 1'b0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (cnt_clr[i]) begin
          cnt_q[i] <= '0;
        end else if (cnt_up[i] && !cnt_dn[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end else if (cnt_dn[i] && !cnt_up[i]) begin
          cnt_q[i] <= cnt_q[i] - 1'b1;
        end
      end
    end
  end

  // Nothing in flight for a class once both its counters are empty
  assign no_ld_pending_o = (cnt_q[SPEC_LD] == '0) && (cnt_q[DISP_LD] == '0);
  assign no_st_pending_o = (cnt_q[SPEC_ST] == '0) && (cnt_q[DISP_ST] == '0);

endmodule

// File: design/acc_dispatcher.sv
// Dispatcher: issue stall, request register, response unpacking and store-barrier halt
`timescale 1ns/1ps

module acc_dispatcher import acc_pkg::*; (
  input  logic          clk_i,
  input  logic          arst_n_i,
  input  logic          cons_en_i,
  input  frm_t          frm_i,
  input  issue_entry_t  issue_i,
  input  logic          issue_hs_i,
  output logic          issue_stall_o,
  input  fu_data_t      fu_data_i,
  input  commit_entry_t commit_i,
  input  logic          flush_unissued_i,
  input  logic          flush_i,
  input  logic          barrier_i,
  input  logic          no_st_pending_i,
  output logic          ctrl_halt_o,
  output trans_id_t     resp_id_o,
  output xlen_t         result_o,
  output logic          resp_valid_o,
  output logic          result_err_o,
  output acc_req_t      acc_req_o,
  input  acc_resp_t     acc_resp_i
);

  logic                             push_d, push_q;
  fu_data_t                         head;
  logic                             q_empty, q_pop;
  logic [$clog2(QUEUE_DEPTH+1)-1:0] q_usage;
  logic                             head_ready;
  logic                             no_ld_pending, no_st_pending;
  acc_req_t                         req_in, reg_data_q;
  logic                             req_in_valid, reg_valid_q, reg_ready;
  logic                             halt_q;

  // Accepted, unfinished, unflushed accelerator instruction
  assign push_d = issue_hs_i & ~issue_stall_o & ~issue_i.valid & (issue_i.fu == ACCEL) &
                  ~flush_unissued_i & ~flush_i;

  // Stall depends on what the issue stage is offering
  always_comb begin
    case (issue_i.fu)
      // Leave room for the instruction sitting in the push flag
      ACCEL:   issue_stall_o = (q_usage >= QUEUE_DEPTH - 1);
      // Scalar load must not pass accelerator stores
      LOAD:    issue_stall_o = cons_en_i & ~no_st_pending;
      // Scalar store must not pass any accelerator access
      STORE:   issue_stall_o = cons_en_i & (~no_st_pending | ~no_ld_pending);
      default: issue_stall_o = 1'b0;
    endcase
  end

  // Operands arrive one cycle after the handshake
  acc_insn_queue u_insn_queue (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .flush_i  (flush_i),
    .push_i   (push_q),
    .data_i   (fu_data_i),
    .pop_i    (q_pop),
    .data_o   (head),
    .empty_o  (q_empty),
    .usage_o  (q_usage)
  );

  acc_spec_tracker u_spec_tracker (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .flush_i      (flush_i),
    .push_i       (push_q),
    .push_id_i    (fu_data_i.trans_id),
    .commit_i     (commit_i),
    .head_id_i    (head.trans_id),
    .disp_i       (acc_req_o.req_valid & acc_resp_i.req_ready),
    .disp_id_i    (acc_req_o.trans_id),
    .head_ready_o (head_ready)
  );

  // Request payload from the queue head, rounding mode sampled now
  always_comb begin
    req_in          = '0;
    req_in.insn     = head.insn;
    req_in.rs1      = head.operand_a;
    req_in.rs2      = head.operand_b;
    req_in.frm      = frm_i;
    req_in.trans_id = head.trans_id;
  end

  // Head leaves once non-speculative
  assign req_in_valid = ~q_empty & head_ready;
  // Fall-through register takes a new entry only while it holds none
  assign reg_ready    = ~reg_valid_q;
  assign q_pop        = req_in_valid & reg_ready;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      reg_valid_q <= 1'b0;
    end else if (q_pop && !acc_resp_i.req_ready) begin
      // Accelerator busy, park the request
      reg_valid_q <= 1'b1;
    end else if (reg_valid_q && acc_resp_i.req_ready) begin
      reg_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (q_pop) begin
      reg_data_q <= req_in;
    end
  end

  always_comb begin
    acc_req_o               = reg_valid_q ? reg_data_q : req_in;
    acc_req_o.req_valid     = reg_valid_q | req_in_valid;
    // Scalar stores still in flight while consistency is on
    acc_req_o.store_pending = ~no_st_pending_i & cons_en_i;
    acc_req_o.cons_en       = cons_en_i;
    // Responses are never back-pressured
    acc_req_o.resp_ready    = 1'b1;
  end

  // Counted at handshake, moved to dispatched at pop
  acc_mem_tracker u_mem_tracker (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .flush_i         (flush_i),
    .spec_ld_i       (push_d & (issue_i.op == ACC_LOAD)),
    .spec_st_i       (push_d & (issue_i.op == ACC_STORE)),
    .disp_ld_i       (q_pop & (head.op == ACC_LOAD)),
    .disp_st_i       (q_pop & (head.op == ACC_STORE)),
    .ld_done_i       (acc_resp_i.load_complete),
    .st_done_i       (acc_resp_i.store_complete),
    .no_ld_pending_o (no_ld_pending),
    .no_st_pending_o (no_st_pending)
  );

  // Response passes straight to writeback
  assign resp_id_o    = acc_resp_i.trans_id;
  assign result_o     = acc_resp_i.result;
  assign resp_valid_o = acc_resp_i.resp_valid;
  assign result_err_o = acc_resp_i.error;

  // Store barrier holds the core until accelerator stores drain
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      push_q <= 1'b0;
      halt_q <= 1'b0;
    end else begin
      push_q <= push_d;
      halt_q <= (halt_q | barrier_i) & acc_resp_i.store_pending;
    end
  end

  assign ctrl_halt_o = halt_q;

endmodule

// File: design/acc_dispatch_top.sv
// Accelerator dispatch subsystem top around the dispatcher
`timescale 1ns/1ps

module acc_dispatch_top import acc_pkg::*; (
  input  logic          clk_i,
  input  logic          arst_n_i,
  input  logic          cons_en_i,
  input  frm_t          frm_i,
  input  issue_entry_t  issue_i,
  input  logic          issue_hs_i,
  output logic          issue_stall_o,
  input  fu_data_t      fu_data_i,
  input  commit_entry_t commit_i,
  input  logic          flush_unissued_i,
  input  logic          flush_i,
  input  logic          barrier_i,
  input  logic          no_st_pending_i,
  output logic          ctrl_halt_o,
  output trans_id_t     resp_id_o,
  output xlen_t         result_o,
  output logic          resp_valid_o,
  output logic          result_err_o,
  output acc_req_t      acc_req_o,
  input  acc_resp_t     acc_resp_i
);

  // Core side and accelerator side both attach here
  acc_dispatcher u_dispatcher (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .cons_en_i        (cons_en_i),
    .frm_i            (frm_i),
    .issue_i          (issue_i),
    .issue_hs_i       (issue_hs_i),
    .issue_stall_o    (issue_stall_o),
    .fu_data_i        (fu_data_i),
    .commit_i         (commit_i),
    .flush_unissued_i (flush_unissued_i),
    .flush_i          (flush_i),
    .barrier_i        (barrier_i),
    .no_st_pending_i  (no_st_pending_i),
    .ctrl_halt_o      (ctrl_halt_o),
    .resp_id_o        (resp_id_o),
    .result_o         (result_o),
    .resp_valid_o     (resp_valid_o),
    .result_err_o     (result_err_o),
    .acc_req_o        (acc_req_o),
    .acc_resp_i       (acc_resp_i)
  );

endmodule

// File: testbench/acc_dispatch_asserts.sv
// Bound assertions on counters, request hold and barrier halt
`timescale 1ns/1ps

module acc_dispatch_asserts import acc_pkg::*; (
  input logic                     clk_i,
  input logic                     arst_n_i,
  input acc_req_t                 req_i,
  input acc_resp_t                resp_i,
  input logic                     halt_i,
  input logic [3:0][CNT_BITS-1:0] cnt_i
);

  // All-ones means an overflow or an underflow happened
  for (genvar i = 0; i < 4; i++) begin : g_cnt
    a_no_wrap: assert property (@(posedge clk_i) disable iff (!arst_n_i) cnt_i[i] != '1)
      else $error("load/store counter %0d wrapped", i);
  end

  // Request must not change or drop before the accelerator takes it
  a_req_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_i.req_valid && !resp_i.req_ready |=> req_i.req_valid && $stable(req_i.insn) &&
    $stable(req_i.rs1) && $stable(req_i.rs2) && $stable(req_i.trans_id))
    else $error("request changed while waiting for ready");

  a_halt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    halt_i |-> $past(resp_i.store_pending))
    else $error("halt without accelerator store pending");

endmodule

bind acc_dispatcher acc_dispatch_asserts u_asserts (
  .clk_i    (clk_i),
  .arst_n_i (arst_n_i),
  .req_i    (acc_req_o),
  .resp_i   (acc_resp_i),
  .halt_i   (ctrl_halt_o),
  .cnt_i    (u_mem_tracker.cnt_q)
);

// File: testbench/tb_clk_gen.sv
// Testbench clock and active-low reset generator
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int CLK_PERIOD_NS = 10,
  parameter int RESET_CYCLES  = 16
) (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(CLK_PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset released on a falling edge, away from DUT sampling
  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

// File: testbench/tb_acc_dispatch.sv
// Directed tests, accelerator model, compare tasks and watchdog for the dispatch unit
`timescale 1ns/1ps

module tb_acc_dispatch import acc_pkg::*; ();

  localparam int   CLK_PERIOD_NS = 10;
  // Rough length of all tests with slack for random back-pressure
  localparam int   TEST_CYCLES   = 2000;
  localparam int   WATCHDOG_NS   = TEST_CYCLES * CLK_PERIOD_NS;
  localparam int   WAIT_LIMIT    = 300;
  localparam frm_t FRM           = 3'b101;

  logic          clk, arst_n;
  logic          cons_en, issue_hs, issue_stall, flush_unissued, flush, barrier;
  logic          no_st_pending, ctrl_halt, resp_valid, result_err;
  issue_entry_t  issue;
  fu_data_t      fu_data;
  commit_entry_t commit;
  trans_id_t     resp_id;
  xlen_t         result;
  acc_req_t      acc_req;
  acc_resp_t     acc_resp;

  // Accelerator model state
  logic          ready_mode, m_req_ready, m_resp_valid, m_error, st_done, acc_st_pend;
  trans_id_t     m_resp_id;
  xlen_t         m_result;
  logic [31:0]   rng;
  fu_data_t      exp_q[$];
  trans_id_t     rsp_id_q[$], exp_id_q[$];
  xlen_t         rsp_res_q[$], exp_res_q[$];
  int            mis_cnt, oth_cnt;

  tb_clk_gen #(.CLK_PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(16)) u_clk_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  acc_dispatch_top u_dut (
    .clk_i (clk), .arst_n_i (arst_n), .cons_en_i (cons_en), .frm_i (FRM),
    .issue_i (issue), .issue_hs_i (issue_hs), .issue_stall_o (issue_stall),
    .fu_data_i (fu_data), .commit_i (commit), .flush_unissued_i (flush_unissued),
    .flush_i (flush), .barrier_i (barrier), .no_st_pending_i (no_st_pending),
    .ctrl_halt_o (ctrl_halt), .resp_id_o (resp_id), .result_o (result),
    .resp_valid_o (resp_valid), .result_err_o (result_err),
    .acc_req_o (acc_req), .acc_resp_i (acc_resp)
  );

  assign acc_resp = '{req_ready: m_req_ready, resp_valid: m_resp_valid, trans_id: m_resp_id,
                      result: m_result, error: m_error, load_complete: 1'b0,
                      store_complete: st_done, store_pending: acc_st_pend};

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    return s;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  task automatic check_id(input string name, input trans_id_t got, input trans_id_t exp);
    if (got !== exp) begin
      mis_cnt++;
      $display("FAIL %0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      mis_cnt++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_insn(input string name, input insn_t got, input insn_t exp);
    if (got !== exp) begin
      mis_cnt++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_frm(input string name, input frm_t got, input frm_t exp);
    if (got !== exp) begin
      mis_cnt++;
      $display("FAIL %0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mis_cnt++;
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // Random ready and one response per cycle, driven on the falling edge
  always @(negedge clk) begin
    if (arst_n) begin
      m_req_ready = ready_mode ? next_rand() >> 3 & 1 : 1'b0;
      m_resp_valid = 1'b0;
      if (rsp_id_q.size() > 0) begin
        m_resp_valid = 1'b1;
        m_resp_id    = rsp_id_q.pop_front();
        m_result     = rsp_res_q.pop_front();
        m_error      = rng[7];
      end
    end
  end

  // Request and response monitor on the rising edge
  always @(posedge clk) begin
    fu_data_t e;
    if (arst_n && acc_req.req_valid && m_req_ready) begin
      if (exp_q.size() == 0) begin
        oth_cnt++;
        $display("Unexpected request with ID %0d at %0t", acc_req.trans_id, $time);
      end else begin
        e = exp_q.pop_front();
        check_insn("acc_req_o.insn", acc_req.insn, e.insn);
        check_word("acc_req_o.rs1", acc_req.rs1, e.operand_a);
        check_word("acc_req_o.rs2", acc_req.rs2, e.operand_b);
        check_id("acc_req_o.trans_id", acc_req.trans_id, e.trans_id);
        check_frm("acc_req_o.frm", acc_req.frm, FRM);
        // Model answers from what it received
        rsp_id_q.push_back(acc_req.trans_id);
        rsp_res_q.push_back(acc_req.rs1 + acc_req.rs2);
        exp_id_q.push_back(e.trans_id);
        exp_res_q.push_back(e.operand_a + e.operand_b);
      end
    end
    if (arst_n && m_resp_valid && exp_id_q.size() > 0) begin
      check_bit("resp_valid_o", resp_valid, 1'b1);
      check_id("resp_id_o", resp_id, exp_id_q.pop_front());
      check_word("result_o", result, exp_res_q.pop_front());
      check_bit("result_err_o", result_err, m_error);
    end
  end

  task automatic issue_accel(input trans_id_t id, input acc_op_e op);
    fu_data_t d;
    int       n;
    d.operand_a = next_rand();
    d.operand_b = next_rand();
    d.insn      = next_rand();
    d.trans_id  = id;
    d.op        = op;
    n = 0;
    @(negedge clk);
    issue    = '{valid: 1'b0, fu: ACCEL, op: op, trans_id: id};
    issue_hs = 1'b1;
    #1;
    while (issue_stall && n < WAIT_LIMIT) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (issue_stall) begin
      oth_cnt++;
      $display("Issue of ID %0d never accepted", id);
    end
    // Operands follow the handshake by one cycle
    @(negedge clk);
    issue_hs = 1'b0;
    issue    = '{valid: 1'b1, fu: NONE, op: OTHER, trans_id: '0};
    fu_data  = d;
    exp_q.push_back(d);
    @(negedge clk);
  endtask

  task automatic commit_id(input trans_id_t id);
    @(negedge clk);
    commit = '{valid: 1'b0, fu: ACCEL, trans_id: id};
    @(negedge clk);
    commit = '{valid: 1'b1, fu: NONE, trans_id: '0};
  endtask

  task automatic offer_stall(input fu_e fu, input logic exp);
    @(negedge clk);
    issue = '{valid: 1'b0, fu: fu, op: OTHER, trans_id: '0};
    #1;
    check_bit("issue_stall_o", issue_stall, exp);
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while ((exp_q.size() + rsp_id_q.size() + exp_id_q.size()) > 0 && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if ((exp_q.size() + rsp_id_q.size() + exp_id_q.size()) > 0) begin
      oth_cnt++;
      $display("Timed out waiting for requests and responses to drain");
    end
    repeat (2) @(negedge clk);
  endtask

  task automatic test_hold();
    ready_mode = 1'b1;
    issue_accel(3'd1, OTHER);
    // Still speculative, nothing may leave
    repeat (10) begin
      @(negedge clk);
      check_bit("acc_req_o.req_valid", acc_req.req_valid, 1'b0);
    end
    commit_id(3'd1);
    wait_idle();
  endtask

  task automatic test_order();
    ready_mode = 1'b1;
    for (int i = 2; i < 7; i++) begin
      issue_accel(trans_id_t'(i), OTHER);
      commit_id(trans_id_t'(i));
    end
    wait_idle();
  endtask

  task automatic test_throttle();
    ready_mode = 1'b0;
    issue_accel(3'd1, OTHER);
    issue_accel(3'd2, OTHER);
    offer_stall(ACCEL, 1'b1);
    ready_mode = 1'b1;
    commit_id(3'd1);
    commit_id(3'd2);
    wait_idle();
    offer_stall(ACCEL, 1'b0);
  endtask

  task automatic test_flush();
    ready_mode = 1'b1;
    issue_accel(3'd3, ACC_STORE);
    issue_accel(3'd4, ACC_LOAD);
    @(negedge clk);
    flush = 1'b1;
    exp_q.delete();
    @(negedge clk);
    flush = 1'b0;
    // Late commit of a flushed ID must be ignored
    commit_id(3'd3);
    repeat (10) @(negedge clk);
    cons_en = 1'b1;
    offer_stall(LOAD, 1'b0);
    offer_stall(STORE, 1'b0);
    cons_en = 1'b0;
  endtask

  task automatic test_consistency();
    ready_mode = 1'b1;
    issue_accel(3'd5, ACC_STORE);
    commit_id(3'd5);
    wait_idle();
    cons_en = 1'b1;
    offer_stall(LOAD, 1'b1);
    offer_stall(STORE, 1'b1);
    cons_en = 1'b0;
    offer_stall(LOAD, 1'b0);
    offer_stall(STORE, 1'b0);
    cons_en = 1'b1;
    @(negedge clk);
    st_done = 1'b1;
    @(negedge clk);
    st_done = 1'b0;
    offer_stall(LOAD, 1'b0);
    offer_stall(STORE, 1'b0);
    // Scalar store state reaches the accelerator only while consistency is on
    no_st_pending = 1'b0;
    #1;
    check_bit("acc_req_o.store_pending", acc_req.store_pending, 1'b1);
    check_bit("acc_req_o.cons_en", acc_req.cons_en, 1'b1);
    cons_en = 1'b0;
    #1;
    check_bit("acc_req_o.store_pending", acc_req.store_pending, 1'b0);
    check_bit("acc_req_o.cons_en", acc_req.cons_en, 1'b0);
    no_st_pending = 1'b1;
  endtask

  task automatic test_barrier();
    @(negedge clk);
    acc_st_pend = 1'b1;
    #1;
    check_bit("ctrl_halt_o", ctrl_halt, 1'b0);
    @(negedge clk);
    barrier = 1'b1;
    @(negedge clk);
    barrier = 1'b0;
    #1;
    check_bit("ctrl_halt_o", ctrl_halt, 1'b1);
    repeat (3) begin
      @(negedge clk);
      check_bit("ctrl_halt_o", ctrl_halt, 1'b1);
    end
    acc_st_pend = 1'b0;
    #1;
    check_bit("ctrl_halt_o", ctrl_halt, 1'b1);
    @(negedge clk);
    #1;
    check_bit("ctrl_halt_o", ctrl_halt, 1'b0);
  endtask

  initial begin
    rng            = 32'h294e;
    mis_cnt        = 0;
    oth_cnt        = 0;
    cons_en        = 1'b0;
    issue          = '{valid: 1'b1, fu: NONE, op: OTHER, trans_id: '0};
    issue_hs       = 1'b0;
    fu_data        = '0;
    commit         = '{valid: 1'b1, fu: NONE, trans_id: '0};
    flush_unissued = 1'b0;
    flush          = 1'b0;
    barrier        = 1'b0;
    no_st_pending  = 1'b1;
    ready_mode     = 1'b0;
    m_req_ready    = 1'b0;
    m_resp_valid   = 1'b0;
    m_resp_id      = '0;
    m_result       = '0;
    m_error        = 1'b0;
    st_done        = 1'b0;
    acc_st_pend    = 1'b0;
    @(posedge arst_n);
    #1;
    // Idle state straight out of reset
    check_bit("acc_req_o.req_valid", acc_req.req_valid, 1'b0);
    check_bit("acc_req_o.resp_ready", acc_req.resp_ready, 1'b1);
    check_bit("ctrl_halt_o", ctrl_halt, 1'b0);
    check_bit("issue_stall_o", issue_stall, 1'b0);
    check_bit("resp_valid_o", resp_valid, 1'b0);
    test_hold();
    test_order();
    test_throttle();
    test_flush();
    test_consistency();
    test_barrier();
    $display("Errors: %0d value mismatches, %0d other failures", mis_cnt, oth_cnt);
    if (mis_cnt == 0 && oth_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests finished");
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: src.f
design/acc_pkg.sv
design/acc_insn_queue.sv
design/acc_spec_tracker.sv
design/acc_mem_tracker.sv
design/acc_dispatcher.sv
design/acc_dispatch_top.sv
testbench/acc_dispatch_asserts.sv
testbench/tb_clk_gen.sv
testbench/tb_acc_dispatch.sv

// File: Makefile
TOP  := tb_acc_dispatch
SRCS := $(shell cat src.f)

obj_dir/V$(TOP): src.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f src.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^TEST PASSED$$'

clean:
	rm -rf obj_dir

.PHONY: run clean
